// ==== run.sh ====
#!/usr/bin/env bash
# build the execute stage testbench with verilator and run it
# exit status is 0 only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps --top-module tb_ex_stage -f vlog.f \
  && ./obj_dir/Vtb_ex_stage | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
  || { echo "simulation did not pass"; exit 1; }

// ==== src/ex_alu.sv ====
//////////////////////////////////////////////////////////////////////
// combinational alu, always ready, no vector modes and no divide
// result_o is don't care for the branch compare operators
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
  input  alu_req_t alu_req_i,
  output word_t    result_o,
  output logic     cmp_o
);

  localparam int unsigned SHAMT_W = $clog2(`EX_XLEN);

  word_t              op_a;
  word_t              op_b;
  logic               is_sub;
  logic               is_signed;
  logic [`EX_XLEN:0]  adder_a;
  logic [`EX_XLEN:0]  adder_b;
  logic [`EX_XLEN:0]  adder_sum;
  logic               less;
  logic               equal;
  logic [SHAMT_W-1:0] shamt;
  logic               shift_left;
  logic               shift_fill;
  word_t              op_a_rev;
  word_t              shift_in;
  logic [`EX_XLEN:0]  shift_ext;
  word_t              shift_raw;
  word_t              shift_raw_rev;
  word_t              shift_res;

  assign op_a = alu_req_i.a;
  assign op_b = alu_req_i.b;

  //////////////////////////////////////////////////////////////////////
  // shared adder
  //////////////////////////////////////////////////////////////////////

  // subtract for everything except add, compares need a - b
  assign is_sub    = (alu_req_i.op != ADD);
  assign is_signed = (alu_req_i.op inside {SLT, LT, GE});

  // one extra bit, sign or zero extended, so the msb of the
  // difference is the less-than flag for both signednesses
  assign adder_a   = {is_signed & op_a[`EX_XLEN-1], op_a};
  assign adder_b   = {is_signed & op_b[`EX_XLEN-1], op_b} ^ {(`EX_XLEN+1){is_sub}};
  assign adder_sum = adder_a + adder_b + {{`EX_XLEN{1'b0}}, is_sub};

  assign less  = adder_sum[`EX_XLEN];
  assign equal = (op_a == op_b);

  //////////////////////////////////////////////////////////////////////
  // barrel shifter
  //////////////////////////////////////////////////////////////////////

  assign shamt      = op_b[SHAMT_W-1:0];
  assign shift_left = (alu_req_i.op == SLL);
  // fill with sign only for arithmetic right
  assign shift_fill = (alu_req_i.op == SRA) & op_a[`EX_XLEN-1];

  // left shift goes through the right shifter on reversed bits
  assign op_a_rev = {<<{op_a}};
  assign shift_in = shift_left ? op_a_rev : op_a;

  assign shift_ext     = $signed({shift_fill, shift_in}) >>> shamt;
  assign shift_raw     = shift_ext[`EX_XLEN-1:0];
  assign shift_raw_rev = {<<{shift_raw}};
  assign shift_res     = shift_left ? shift_raw_rev : shift_raw;

  //////////////////////////////////////////////////////////////////////
  // result and compare select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    cmp_o    = 1'b0;
    case (alu_req_i.op)
      ADD, SUB:       result_o = adder_sum[`EX_XLEN-1:0];
      XOR:            result_o = op_a ^ op_b;
      OR:             result_o = op_a | op_b;
      AND:            result_o = op_a & op_b;
      SLL, SRL, SRA:  result_o = shift_res;
      SLT, SLTU: begin
        // zero extended flag
        result_o = {{(`EX_XLEN-1){1'b0}}, less};
        cmp_o    = less;
      end
      EQ:             cmp_o = equal;
      NE:             cmp_o = ~equal;
      LT, LTU:        cmp_o = less;
      GE, GEU:        cmp_o = ~less;
      default:        result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/ex_macros.svh ====
//////////////////////////////////////////////////////////////////////
// width constants for the execute stage, fixed at build time
// the register address top bit selects the upper register bank
//////////////////////////////////////////////////////////////////////

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////////////

// one data word
`define EX_XLEN 32

// register file address, msb picks the upper bank
`define EX_REG_ADDR_W 6

// operator codes
`define EX_ALU_OP_W 4
`define EX_MULT_OP_W 2

`endif

// ==== src/ex_mult.sv ====
//////////////////////////////////////////////////////////////////////
// MUL is single cycle, high word ops take two cycles and stall EX
// the registered product is held until ex_ready_i is seen high
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_macros.svh"

module ex_mult import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  mult_req_t mult_req_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  mult_state_e                 state_q;
  mult_state_e                 state_d;
  logic                        high_op;
  logic                        high_issue;
  logic                        sign_a;
  logic                        sign_b;
  logic signed [2*`EX_XLEN-1:0] ext_a;
  logic signed [2*`EX_XLEN-1:0] ext_b;
  dword_t                      prod;
  dword_t                      prod_q;

  //////////////////////////////////////////////////////////////////////
  // operand extension and product
  //////////////////////////////////////////////////////////////////////

  assign high_op = (mult_req_i.op != MUL);

  // a is signed for MULH and MULHSU, b only for MULH
  assign sign_a = (mult_req_i.op inside {MULH, MULHSU}) & mult_req_i.a[`EX_XLEN-1];
  assign sign_b = (mult_req_i.op == MULH) & mult_req_i.b[`EX_XLEN-1];

  assign ext_a = {{`EX_XLEN{sign_a}}, mult_req_i.a};
  assign ext_b = {{`EX_XLEN{sign_b}}, mult_req_i.b};
  // low 64 bits of the extended product are exact
  assign prod  = ext_a * ext_b;

  // first cycle of a high op
  assign high_issue   = (state_q == MULT_IDLE) & mult_req_i.en & high_op;
  assign ready_o      = ~high_issue;
  assign multicycle_o = high_issue;

  assign result_o = (state_q == MULT_HIGH) ? prod_q[2*`EX_XLEN-1:`EX_XLEN]
                                           : prod[`EX_XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: if (high_issue) state_d = MULT_HIGH;
      // wait out back-pressure from later stages
      MULT_HIGH: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // product captured once, at the issue edge
  always_ff @(posedge clk) begin
    if (high_issue) begin
      prod_q <= prod;
    end
  end

  // decode holds the high operator until the stage moves on
  a_high_entry: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == MULT_HIGH |-> mult_req_i.en && high_op)
    else $error("ex_mult in MULT_HIGH without an enabled high operator");

  // stall only in the first cycle after the stage advanced
  a_ready_issue: assert property (@(posedge clk) disable iff (!rst_n)
    mult_req_i.en && high_op |-> ready_o == !$past(ex_ready_i))
    else $error("ex_mult ready_o not low exactly in the issue cycle");

endmodule

`default_nettype wire

// ==== src/ex_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the execute stage, widths come from ex_macros.svh
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

  // plain vectors with a meaning
  typedef logic [`EX_XLEN-1:0]       word_t;
  typedef logic [2*`EX_XLEN-1:0]     dword_t;
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // alu operators, branch compares in the top half
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD, SUB, XOR, OR, AND, SLL, SRL, SRA,
    SLT, SLTU, EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  // MULH signed x signed, MULHSU signed x unsigned
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MUL, MULH, MULHSU, MULHU
  } mult_op_e;

  // high word multiply sequencing
  typedef enum logic {
    MULT_IDLE, MULT_HIGH
  } mult_state_e;

  // alu request, operand c is the jump target
  typedef struct packed {
    logic    en;
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  typedef struct packed {
    logic     en;
    mult_op_e op;
    word_t    a;
    word_t    b;
  } mult_req_t;

  // one register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

endpackage

`default_nettype wire

// ==== src/ex_stage.sv ====
//////////////////////////////////////////////////////////////////////
// integer execute stage top, alu and multiplier into writeback
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // unit requests
  input  alu_req_t  alu_req_i,
  input  mult_req_t mult_req_i,
  // csr and lsu
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  // stage control
  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,
  // register writes from decode
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  // write ports
  output rf_wr_t    fw_wr_o,
  output rf_wr_t    wb_wr_o,
  // branch
  output word_t     jump_target_o,
  output logic      branch_decision_o,
  // stage status
  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;

  // branch target and decision straight to fetch
  assign jump_target_o     = alu_req_i.c;
  assign branch_decision_o = alu_cmp;

  ex_alu i_alu (
    .alu_req_i (alu_req_i),
    .result_o  (alu_result),
    .cmp_o     (alu_cmp)
  );

  // stage ready closes the loop on the multiplier
  ex_mult i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback i_wb (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_req_i.en),
    .alu_result_i        (alu_result),
    .mult_en_i           (mult_req_i.en),
    .mult_result_i       (mult_result),
    .mult_ready_i        (mult_ready),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .wb_ready_i          (wb_ready_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .fw_wr_o             (fw_wr_o),
    .wb_wr_o             (wb_wr_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

`default_nettype wire

// ==== src/ex_writeback.sv ====
//////////////////////////////////////////////////////////////////////
// forwarding mux, EX/WB register and stage strobes
// decode must enable at most one of alu, multiplier and csr access
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ex_writeback import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // unit enables and results
  input  logic      alu_en_i,
  input  word_t     alu_result_i,
  input  logic      mult_en_i,
  input  word_t     mult_result_i,
  input  logic      mult_ready_i,
  // csr and lsu
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  // stage control
  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,
  // register writes from decode
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  output rf_wr_t    fw_wr_o,
  output rf_wr_t    wb_wr_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  logic      wb_we_q;
  reg_addr_t wb_waddr_q;
  logic      units_ready;
  logic      any_en;

  //////////////////////////////////////////////////////////////////////
  // forwarding port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_wr_o.we   = regfile_alu_we_i;
    fw_wr_o.addr = regfile_alu_waddr_i;
    // csr wins, then multiplier, then alu
    if (csr_access_i) begin
      fw_wr_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_wr_o.data = mult_result_i;
    end else if (alu_en_i) begin
      fw_wr_o.data = alu_result_i;
    end else begin
      fw_wr_o.data = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register, load write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      wb_we_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      // nothing new, flush the old write out
      wb_we_q <= 1'b0;
    end
  end

  // address only follows a real write
  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i) begin
      wb_waddr_q <= regfile_waddr_i;
    end
  end

  assign wb_wr_o.we   = wb_we_q;
  assign wb_wr_o.addr = wb_waddr_q;
  assign wb_wr_o.data = lsu_rdata_i;

  // a branch in EX frees the stage even while a unit stalls
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;
  assign ex_valid_o  = any_en & units_ready;
  assign ex_ready_o  = units_ready | branch_in_ex_i;

  a_onehot_src: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, csr_access_i}))
    else $error("ex_writeback more than one forwarding source enabled");

  // enable and address are captured at the same valid edge
  a_we_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_we_q) |-> $past(ex_valid_o) && wb_waddr_q == $past(regfile_waddr_i))
    else $error("ex_writeback load port write rose without a valid write");

endmodule

`default_nettype wire

// ==== tb/tb_ex_stage.sv ====
//////////////////////////////////////////////////////////////////////
// inputs change on the falling edge, outputs sampled 1 ns later
// expected values come from the ISA rules, not from the DUT
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 20;

  logic      clk;
  logic      rst_n;
  alu_req_t  alu_req;
  mult_req_t mult_req;
  logic      csr_access;
  word_t     csr_rdata;
  logic      lsu_en;
  word_t     lsu_rdata;
  logic      lsu_ready_ex;
  logic      branch_in_ex;
  logic      wb_ready;
  logic      regfile_alu_we;
  reg_addr_t regfile_alu_waddr;
  logic      regfile_we;
  reg_addr_t regfile_waddr;
  rf_wr_t    fw_wr;
  rf_wr_t    wb_wr;
  word_t     jump_target;
  logic      branch_decision;
  logic      mult_multicycle;
  logic      ex_ready;
  logic      ex_valid;
  int        errors;
  word_t     rand_state;

  ex_stage i_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .mult_req_i          (mult_req),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .branch_in_ex_i      (branch_in_ex),
    .wb_ready_i          (wb_ready),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .fw_wr_o             (fw_wr),
    .wb_wr_o             (wb_wr),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  // lcg, numerical recipes constants
  function word_t next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic word_t alu_expect(alu_op_e op, word_t a, word_t b);
    word_t r;
    case (op)
      ADD:     r = a + b;
      SUB:     r = a - b;
      XOR:     r = a ^ b;
      OR:      r = a | b;
      AND:     r = a & b;
      SLL:     r = a << b[4:0];
      SRL:     r = a >> b[4:0];
      SRA:     r = $signed(a) >>> b[4:0];
      SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:    r = (a < b) ? 32'd1 : 32'd0;
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic branch_expect(alu_op_e op, word_t a, word_t b);
    case (op)
      EQ:      return a == b;
      NE:      return a != b;
      LT:      return $signed(a) < $signed(b);
      GE:      return $signed(a) >= $signed(b);
      LTU:     return a < b;
      default: return a >= b;
    endcase
  endfunction

  // signed high words from the unsigned product minus the sign corrections
  function automatic word_t mult_expect(mult_op_e op, word_t a, word_t b);
    dword_t pu;
    word_t  hi;
    pu = {32'b0, a} * {32'b0, b};
    hi = pu[63:32];
    case (op)
      MUL:     return pu[31:0];
      MULHU:   return hi;
      MULHSU:  return hi - (a[31] ? b : 32'd0);
      default: return hi - (a[31] ? b : 32'd0) - (b[31] ? a : 32'd0);
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drive and check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      errors = errors + 1;
      $display("CHECK FAILED %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_fw(input word_t exp);
    check_value("fw_wr_o.we", word_t'(fw_wr.we), 32'd1);
    check_value("fw_wr_o.addr", word_t'(fw_wr.addr), word_t'(regfile_alu_waddr));
    check_value("fw_wr_o.data", fw_wr.data, exp);
  endtask

  task automatic drive_idle();
    alu_req           = '0;
    mult_req          = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
  endtask

  // every cycle starts idle at the falling edge
  task automatic start_cycle();
    @(negedge clk);
    drive_idle();
  endtask

  task automatic drive_mult(input mult_op_e op, input word_t a, input word_t b,
                            input reg_addr_t addr);
    mult_req.en       = 1'b1;
    mult_req.op       = op;
    mult_req.a        = a;
    mult_req.b        = b;
    regfile_alu_we    = 1'b1;
    regfile_alu_waddr = addr;
  endtask

  // inputs hold while waiting
  task automatic wait_ready(output int cycles);
    cycles = 0;
    while (!ex_ready && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!ex_ready) begin
      errors = errors + 1;
      $display("timeout waiting for ex_ready_o after %0d cycles", cycles);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequences
  //////////////////////////////////////////////////////////////////////

  task automatic alu_ops();
    word_t a;
    word_t b;
    for (int k = int'(ADD); k <= int'(SLTU); k++) begin
      for (int n = 0; n < 6; n++) begin
        // first pair splits signed from unsigned compare
        a = (n == 0) ? 32'h8000_0000 : next_rand();
        b = (n == 0) ? 32'h7fff_ffff : next_rand();
        start_cycle();
        alu_req.en        = 1'b1;
        alu_req.op        = alu_op_e'(k);
        alu_req.a         = a;
        alu_req.b         = b;
        alu_req.c         = next_rand();
        regfile_alu_we    = 1'b1;
        regfile_alu_waddr = reg_addr_t'(next_rand());
        #1;
        check_fw(alu_expect(alu_op_e'(k), a, b));
      end
    end
  endtask

  task automatic branch_ops();
    word_t a;
    word_t b;
    for (int k = int'(EQ); k <= int'(GEU); k++) begin
      for (int n = 0; n < 6; n++) begin
        a = next_rand();
        b = (n == 0) ? a : next_rand();
        start_cycle();
        alu_req.en   = 1'b1;
        alu_req.op   = alu_op_e'(k);
        alu_req.a    = a;
        alu_req.b    = b;
        alu_req.c    = next_rand();
        branch_in_ex = 1'b1;
        // ready must come from the branch alone when wb stalls
        wb_ready     = (n % 2 == 0);
        #1;
        check_value("branch_decision_o", word_t'(branch_decision),
                    word_t'(branch_expect(alu_op_e'(k), a, b)));
        check_value("jump_target_o", jump_target, alu_req.c);
        check_value("ex_ready_o", word_t'(ex_ready), 32'd1);
      end
    end
  endtask

  task automatic mul_low();
    word_t a;
    word_t b;
    for (int n = 0; n < 6; n++) begin
      a = next_rand();
      b = next_rand();
      start_cycle();
      drive_mult(MUL, a, b, reg_addr_t'(next_rand()));
      #1;
      check_value("ex_ready_o", word_t'(ex_ready), 32'd1);
      check_value("mult_multicycle_o", word_t'(mult_multicycle), 32'd0);
      check_fw(mult_expect(MUL, a, b));
    end
  endtask

  task automatic mul_high(input mult_op_e op, input word_t a, input word_t b, input bit stall);
    word_t     exp;
    reg_addr_t addr;
    int        cycles;
    exp  = mult_expect(op, a, b);
    addr = reg_addr_t'(next_rand());
    // issue cycle stalls the stage
    start_cycle();
    drive_mult(op, a, b, addr);
    wb_ready = !stall;
    #1;
    check_value("ex_ready_o", word_t'(ex_ready), 32'd0);
    check_value("mult_multicycle_o", word_t'(mult_multicycle), 32'd1);
    if (stall) begin
      repeat (3) begin
        start_cycle();
        drive_mult(op, a, b, addr);
        wb_ready = 1'b0;
        #1;
        check_value("ex_ready_o", word_t'(ex_ready), 32'd0);
        check_value("fw_wr_o.data", fw_wr.data, exp);
      end
      // back-pressure released
      start_cycle();
      drive_mult(op, a, b, addr);
      #1;
    end
    wait_ready(cycles);
    check_value("mult latency", word_t'(cycles), stall ? 32'd0 : 32'd1);
    check_value("mult_multicycle_o", word_t'(mult_multicycle), 32'd0);
    check_fw(exp);
  endtask

  task automatic csr_forward();
    for (int n = 0; n < 4; n++) begin
      start_cycle();
      csr_access        = 1'b1;
      csr_rdata         = next_rand();
      alu_req.a         = next_rand();
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = reg_addr_t'(next_rand());
      #1;
      check_fw(csr_rdata);
    end
  endtask

  task automatic exwb_register();
    reg_addr_t addr;
    for (int n = 0; n < 4; n++) begin
      addr = reg_addr_t'(next_rand());
      start_cycle();
      // valid from the alu or from a load
      if (n % 2 == 0) alu_req.en = 1'b1;
      else lsu_en = 1'b1;
      regfile_we    = 1'b1;
      regfile_waddr = addr;
      #1;
      check_value("ex_valid_o", word_t'(ex_valid), 32'd1);
      start_cycle();
      lsu_rdata = next_rand();
      #1;
      check_value("wb_wr_o.we", word_t'(wb_wr.we), 32'd1);
      check_value("wb_wr_o.addr", word_t'(wb_wr.addr), word_t'(addr));
      check_value("wb_wr_o.data", wb_wr.data, lsu_rdata);
      // idle edge with wb ready clears the write, address stays
      start_cycle();
      #1;
      check_value("wb_wr_o.we", word_t'(wb_wr.we), 32'd0);
      check_value("wb_wr_o.addr", word_t'(wb_wr.addr), word_t'(addr));
    end
    // write enable holds while wb stalls
    start_cycle();
    alu_req.en = 1'b1;
    regfile_we = 1'b1;
    for (int n = 0; n < 4; n++) begin
      start_cycle();
      wb_ready = (n == 2);
      #1;
      check_value("wb_wr_o.we", word_t'(wb_wr.we), (n < 3) ? 32'd1 : 32'd0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // always-on checks
  //////////////////////////////////////////////////////////////////////

  a_branch_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex |-> ex_ready)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED ex_ready_o expected 1 got %h with branch in EX", ex_ready);
    end

  a_jump_target: assert property (@(posedge clk) disable iff (!rst_n)
    jump_target == alu_req.c)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED jump_target_o expected %h got %h", alu_req.c, jump_target);
    end

  initial begin
    errors     = 0;
    rand_state = 32'h02ac_2b87;
    rst_n      = 1'b0;
    drive_idle();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value("wb_wr_o.we", word_t'(wb_wr.we), 32'd0);
    check_value("mult_multicycle_o", word_t'(mult_multicycle), 32'd0);
    alu_ops();
    branch_ops();
    mul_low();
    for (int k = int'(MULH); k <= int'(MULHU); k++) begin
      for (int n = 0; n < 4; n++) begin
        mul_high(mult_op_e'(k),
                 (n == 0) ? 32'h8000_0000 : next_rand(),
                 (n == 0) ? 32'hffff_ffff : next_rand(),
                 n == 3);
      end
    end
    csr_forward();
    exwb_register();
    start_cycle();
    $display("error count %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_writeback.sv
src/ex_stage.sv
tb/tb_ex_stage.sv
